// ==== files.f ====
+incdir+hw
hw/vmux_pkg.sv
hw/vmux_result_fifo.sv
hw/vmux_alu_unit.sv
hw/vmux_mul_unit.sv
hw/vmux_result_arbiter.sv
hw/vmux_top.sv
verification/vmux_assert.sv
verification/vmux_tb.sv

// ==== Bender.yml ====
package:
  name: vmux

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/vmux_pkg.sv
      - hw/vmux_result_fifo.sv
      - hw/vmux_alu_unit.sv
      - hw/vmux_mul_unit.sv
      - hw/vmux_result_arbiter.sv
      - hw/vmux_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/vmux_assert.sv
      - verification/vmux_tb.sv

// ==== verification/vmux_tb.sv ====
/* Vector dispatcher testbench
   Random instructions under random back-pressure, checked against a beat model */

`timescale 1ns/1ps
`default_nettype none

`include "vmux_params.svh"

module vmux_tb import vmux_pkg::*;;

    localparam int N_INSTR    = 300;
    localparam int CLK_PERIOD = 4;

    logic      clk_i;
    logic      async_rst_ni;
    logic      in_valid_i;
    logic      in_ready_o;
    ctrl_t     in_ctrl_i;
    operands_t in_operands_i;
    logic      out_valid_o;
    logic      out_ready_i;
    res_beat_t out_beat_o;

    res_beat_t alu_q[$];
    res_beat_t mul_q[$];

    vmux_top dut (
        .clk_i         ( clk_i         ),
        .async_rst_ni  ( async_rst_ni  ),
        .in_valid_i    ( in_valid_i    ),
        .in_ready_o    ( in_ready_o    ),
        .in_ctrl_i     ( in_ctrl_i     ),
        .in_operands_i ( in_operands_i ),
        .out_valid_o   ( out_valid_o   ),
        .out_ready_i   ( out_ready_i   ),
        .out_beat_o    ( out_beat_o    )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Expected beat for element e of one instruction
    function automatic res_beat_t model_beat(ctrl_t c, operands_t o, int e);
        logic [`VMUX_ELEM_W-1:0] a;
        logic [`VMUX_ELEM_W-1:0] b;
        logic [`VMUX_ELEM_W-1:0] r8;
        res_beat_t               bt;
        a = o.op_a[e*`VMUX_ELEM_W +: `VMUX_ELEM_W];
        b = o.op_b[e*`VMUX_ELEM_W +: `VMUX_ELEM_W];
        case (c.op)
            OP_ADD:  r8 = a + b;
            OP_SUB:  r8 = a - b;
            OP_AND:  r8 = a & b;
            default: r8 = a ^ b;
        endcase
        bt.id   = c.id;
        bt.unit = c.unit;
        bt.elem = ELEM_IDX_W'(e);
        bt.last = (e == int'(c.vl_m1));
        if (c.unit == UNIT_MUL) begin
            bt.data = {8'h00, a} * {8'h00, b};
        end else begin
            bt.data = {8'h00, r8};
        end
        return bt;
    endfunction

    task automatic add_expected(ctrl_t c, operands_t o);
        for (int e = 0; e <= int'(c.vl_m1); e++) begin
            if (c.unit == UNIT_ALU) begin
                alu_q.push_back(model_beat(c, o, e));
            end else begin
                mul_q.push_back(model_beat(c, o, e));
            end
        end
    endtask

    task automatic compare_output(res_beat_t act);
        res_beat_t exp;
        if (act.unit == UNIT_ALU && alu_q.size() == 0) begin
            report_failure("ALU beat arrived with no ALU beat outstanding");
        end else if (act.unit == UNIT_MUL && mul_q.size() == 0) begin
            report_failure("multiply beat arrived with no multiply beat outstanding");
        end else begin
            exp = (act.unit == UNIT_ALU) ? alu_q.pop_front() : mul_q.pop_front();
            check_value((act.unit == UNIT_ALU) ? "alu beat" : "mul beat", exp, act);
        end
    endtask

    // Monitor samples at the edge before any driven update lands
    always @(posedge clk_i) begin
        if (async_rst_ni) begin
            if (!in_valid_i) begin
                check_value("idle in_ready", 1, in_ready_o);
            end
            if (in_valid_i && in_ready_o) begin
                add_expected(in_ctrl_i, in_operands_i);
            end
            if (out_valid_o && out_ready_i) begin
                compare_output(out_beat_o);
            end
        end
    end

    // Output back-pressure in about 30% of cycles
    always @(posedge clk_i) begin
        out_ready_i <= ($urandom_range(0, 99) >= 30);
    end

    initial begin
        #(N_INSTR * 4 * 20 * CLK_PERIOD);
        report_failure("timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        ctrl_t c;
        int    gap;
        void'($urandom(7586));
        clk_i         = 1'b0;
        async_rst_ni  = 1'b0;
        in_valid_i    = 1'b0;
        in_ctrl_i     = '0;
        in_operands_i = '0;
        out_ready_i   = 1'b0;
        repeat (16) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        for (int i = 0; i < N_INSTR; i++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) @(posedge clk_i);
            c.unit  = unit_e'($urandom_range(0, 1));
            c.op    = alu_op_e'($urandom_range(0, 3));
            c.id    = `VMUX_ID_W'($urandom());
            c.vl_m1 = ELEM_IDX_W'($urandom_range(0, 3));
            in_valid_i    <= 1'b1;
            in_ctrl_i     <= c;
            in_operands_i <= operands_t'({$urandom(), $urandom()});
            @(posedge clk_i);
            while (!in_ready_o) @(posedge clk_i);
            in_valid_i <= 1'b0;
        end
        // The monitor records the final transfer at the edge just taken
        @(posedge clk_i);
        while (alu_q.size() != 0 || mul_q.size() != 0) @(posedge clk_i);
        // Extra cycles catch any beat beyond the expected ones
        repeat (20) @(posedge clk_i);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/vmux_assert.sv ====
/* Dispatcher output and input handshake assertions
   Bound into the top level */

`timescale 1ns/1ps
`default_nettype none

module vmux_assert import vmux_pkg::*; (
    input wire logic      clk_i,
    input wire logic      async_rst_ni,
    input wire logic      in_valid_i,
    input wire logic      in_ready_i,
    input wire logic      out_valid_i,
    input wire logic      out_ready_i,
    input wire res_beat_t out_beat_i
);

    logic  open_q;
    unit_e open_unit_q;

    // Tracks an instruction whose last beat has not left yet
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            open_q      <= 1'b0;
            open_unit_q <= UNIT_ALU;
        end else if (out_valid_i && out_ready_i) begin
            open_q      <= ~out_beat_i.last;
            open_unit_q <= out_beat_i.unit;
        end
    end

    stall_holds_beat: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_beat_i))
        else $error("output beat changed while stalled");

    beats_contiguous: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i && open_q |-> out_beat_i.unit == open_unit_q)
        else $error("beats of another unit entered an open instruction");

    idle_input_ready: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !in_valid_i |-> in_ready_i)
        else $error("input ready low while no instruction is offered");

endmodule

bind vmux_top vmux_assert i_vmux_assert (
    .clk_i        ( clk_i        ),
    .async_rst_ni ( async_rst_ni ),
    .in_valid_i   ( in_valid_i   ),
    .in_ready_i   ( in_ready_o   ),
    .out_valid_i  ( out_valid_o  ),
    .out_ready_i  ( out_ready_i  ),
    .out_beat_i   ( out_beat_o   )
);

`default_nettype wire

// ==== hw/vmux_top.sv ====
/* Vector unit dispatcher
   Steers instructions to the ALU or multiply unit and merges their results */

`timescale 1ns/1ps
`default_nettype none

module vmux_top import vmux_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      async_rst_ni,
    input  wire logic      in_valid_i,
    output logic           in_ready_o,
    input  wire ctrl_t     in_ctrl_i,
    input  wire operands_t in_operands_i,
    output logic           out_valid_o,
    input  wire logic      out_ready_i,
    output res_beat_t      out_beat_o
);

    logic      alu_in_valid;
    logic      alu_in_ready;
    logic      mul_in_valid;
    logic      mul_in_ready;
    logic      alu_res_valid;
    logic      alu_res_ready;
    res_beat_t alu_res_beat;
    logic      mul_res_valid;
    logic      mul_res_ready;
    res_beat_t mul_res_beat;

    always_comb begin
        alu_in_valid = in_valid_i & (in_ctrl_i.unit == UNIT_ALU);
        mul_in_valid = in_valid_i & (in_ctrl_i.unit == UNIT_MUL);
        // Ready while nothing is offered
        in_ready_o   = 1'b1;
        if (in_valid_i) begin
            in_ready_o = (in_ctrl_i.unit == UNIT_ALU) ? alu_in_ready : mul_in_ready;
        end
    end

    vmux_alu_unit i_alu (
        .clk_i         ( clk_i         ),
        .async_rst_ni  ( async_rst_ni  ),
        .in_valid_i    ( alu_in_valid  ),
        .in_ready_o    ( alu_in_ready  ),
        .in_ctrl_i     ( in_ctrl_i     ),
        .in_operands_i ( in_operands_i ),
        .res_valid_o   ( alu_res_valid ),
        .res_ready_i   ( alu_res_ready ),
        .res_beat_o    ( alu_res_beat  )
    );

    vmux_mul_unit i_mul (
        .clk_i         ( clk_i         ),
        .async_rst_ni  ( async_rst_ni  ),
        .in_valid_i    ( mul_in_valid  ),
        .in_ready_o    ( mul_in_ready  ),
        .in_ctrl_i     ( in_ctrl_i     ),
        .in_operands_i ( in_operands_i ),
        .res_valid_o   ( mul_res_valid ),
        .res_ready_i   ( mul_res_ready ),
        .res_beat_o    ( mul_res_beat  )
    );

    vmux_result_arbiter i_arb (
        .clk_i        ( clk_i         ),
        .async_rst_ni ( async_rst_ni  ),
        .alu_valid_i  ( alu_res_valid ),
        .alu_ready_o  ( alu_res_ready ),
        .alu_beat_i   ( alu_res_beat  ),
        .mul_valid_i  ( mul_res_valid ),
        .mul_ready_o  ( mul_res_ready ),
        .mul_beat_i   ( mul_res_beat  ),
        .out_valid_o  ( out_valid_o   ),
        .out_ready_i  ( out_ready_i   ),
        .out_beat_o   ( out_beat_o    )
    );

endmodule

`default_nettype wire

// ==== hw/vmux_result_arbiter.sv ====
/* Result arbiter
   Merges the unit result streams, keeping one unit on the output per instruction */

`timescale 1ns/1ps
`default_nettype none

module vmux_result_arbiter import vmux_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      async_rst_ni,
    input  wire logic      alu_valid_i,
    output logic           alu_ready_o,
    input  wire res_beat_t alu_beat_i,
    input  wire logic      mul_valid_i,
    output logic           mul_ready_o,
    input  wire res_beat_t mul_beat_i,
    output logic           out_valid_o,
    input  wire logic      out_ready_i,
    output res_beat_t      out_beat_o
);

    logic  lock_q;
    logic  lock_d;
    unit_e lock_unit_q;
    unit_e lock_unit_d;
    unit_e sel;

    // Fixed priority when unlocked, ALU first
    always_comb begin
        if (lock_q) begin
            sel = lock_unit_q;
        end else if (alu_valid_i) begin
            sel = UNIT_ALU;
        end else begin
            sel = UNIT_MUL;
        end
    end

    assign out_valid_o = (sel == UNIT_ALU) ? alu_valid_i : mul_valid_i;
    assign out_beat_o  = (sel == UNIT_ALU) ? alu_beat_i  : mul_beat_i;

    // Only the selected unit sees ready, the other one waits
    assign alu_ready_o = out_ready_i & (sel == UNIT_ALU);
    assign mul_ready_o = out_ready_i & (sel == UNIT_MUL);

    always_comb begin
        lock_d      = lock_q;
        lock_unit_d = lock_unit_q;
        if (out_valid_o) begin
            lock_unit_d = sel;
            // A stalled beat also pins the choice so the output holds
            if (out_ready_i) begin
                lock_d = ~out_beat_o.last;
            end else begin
                lock_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            lock_q      <= 1'b0;
            lock_unit_q <= UNIT_ALU;
        end else begin
            lock_q      <= lock_d;
            lock_unit_q <= lock_unit_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/vmux_mul_unit.sv ====
/* Multiply unit
   Element sequencer with a registered 8x8 product stage in front of its FIFO */

`timescale 1ns/1ps
`default_nettype none

`include "vmux_params.svh"

module vmux_mul_unit import vmux_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      async_rst_ni,
    input  wire logic      in_valid_i,
    output logic           in_ready_o,
    input  wire ctrl_t     in_ctrl_i,
    input  wire operands_t in_operands_i,
    output logic           res_valid_o,
    input  wire logic      res_ready_i,
    output res_beat_t      res_beat_o
);

    logic                    busy_q;
    logic [ELEM_IDX_W-1:0]   elem_q;
    ctrl_t                   ctrl_q;
    operands_t               opnds_q;
    logic                    stage_valid_q;
    res_beat_t               stage_beat_q;
    logic                    accept;
    logic                    issue;
    logic                    push;
    logic                    last;
    logic                    fifo_full;
    logic                    fifo_afull;
    logic [`VMUX_ELEM_W-1:0] a_elem;
    logic [`VMUX_ELEM_W-1:0] b_elem;
    logic [`VMUX_RES_W-1:0]  product;

    assign in_ready_o = ~busy_q;
    assign accept     = in_valid_i & ~busy_q;
    assign last       = (elem_q == ctrl_q.vl_m1);

    // A full stage may only be refilled when its beat drains and leaves room behind it
    assign push  = stage_valid_q & ~fifo_full;
    assign issue = busy_q & (~stage_valid_q | (~fifo_full & ~fifo_afull));

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            elem_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            elem_q <= '0;
        end else if (issue) begin
            busy_q <= ~last;
            elem_q <= elem_q + ELEM_IDX_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ctrl_q  <= in_ctrl_i;
            opnds_q <= in_operands_i;
        end
    end

    assign a_elem  = elem_sel(opnds_q.op_a, elem_q);
    assign b_elem  = elem_sel(opnds_q.op_b, elem_q);
    assign product = `VMUX_RES_W'(a_elem) * `VMUX_RES_W'(b_elem);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            stage_valid_q <= 1'b0;
        end else if (issue) begin
            stage_valid_q <= 1'b1;
        end else if (push) begin
            stage_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            stage_beat_q.id   <= ctrl_q.id;
            stage_beat_q.unit <= UNIT_MUL;
            stage_beat_q.elem <= elem_q;
            stage_beat_q.last <= last;
            stage_beat_q.data <= product;
        end
    end

    vmux_result_fifo #(
        .PAYLOAD_T     ( res_beat_t       ),
        .DEPTH         ( `VMUX_FIFO_DEPTH )
    ) i_fifo (
        .clk_i         ( clk_i            ),
        .async_rst_ni  ( async_rst_ni     ),
        .push_i        ( push             ),
        .push_data_i   ( stage_beat_q     ),
        .full_o        ( fifo_full        ),
        .almost_full_o ( fifo_afull       ),
        .pop_valid_o   ( res_valid_o      ),
        .pop_ready_i   ( res_ready_i      ),
        .pop_data_o    ( res_beat_o       )
    );

endmodule

`default_nettype wire

// ==== hw/vmux_alu_unit.sv ====
/* ALU unit
   Walks the elements of one instruction and pushes one result beat per cycle */

`timescale 1ns/1ps
`default_nettype none

`include "vmux_params.svh"

module vmux_alu_unit import vmux_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      async_rst_ni,
    input  wire logic      in_valid_i,
    output logic           in_ready_o,
    input  wire ctrl_t     in_ctrl_i,
    input  wire operands_t in_operands_i,
    output logic           res_valid_o,
    input  wire logic      res_ready_i,
    output res_beat_t      res_beat_o
);

    logic                    busy_q;
    logic [ELEM_IDX_W-1:0]   elem_q;
    ctrl_t                   ctrl_q;
    operands_t               opnds_q;
    logic                    accept;
    logic                    issue;
    logic                    last;
    logic                    fifo_full;
    logic [`VMUX_ELEM_W-1:0] a_elem;
    logic [`VMUX_ELEM_W-1:0] b_elem;
    logic [`VMUX_ELEM_W-1:0] alu_res;
    res_beat_t               beat;

    assign in_ready_o = ~busy_q;
    assign accept     = in_valid_i & ~busy_q;
    assign issue      = busy_q & ~fifo_full;
    assign last       = (elem_q == ctrl_q.vl_m1);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            elem_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            elem_q <= '0;
        end else if (issue) begin
            busy_q <= ~last;
            elem_q <= elem_q + ELEM_IDX_W'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            ctrl_q  <= in_ctrl_i;
            opnds_q <= in_operands_i;
        end
    end

    assign a_elem = elem_sel(opnds_q.op_a, elem_q);
    assign b_elem = elem_sel(opnds_q.op_b, elem_q);

    // 8-bit result that wraps on overflow
    always_comb begin
        unique case (ctrl_q.op)
            OP_ADD: alu_res = a_elem + b_elem;
            OP_SUB: alu_res = a_elem - b_elem;
            OP_AND: alu_res = a_elem & b_elem;
            OP_XOR: alu_res = a_elem ^ b_elem;
        endcase
    end

    always_comb begin
        beat.id   = ctrl_q.id;
        beat.unit = UNIT_ALU;
        beat.elem = elem_q;
        beat.last = last;
        beat.data = `VMUX_RES_W'(alu_res);
    end

    vmux_result_fifo #(
        .PAYLOAD_T     ( res_beat_t       ),
        .DEPTH         ( `VMUX_FIFO_DEPTH )
    ) i_fifo (
        .clk_i         ( clk_i            ),
        .async_rst_ni  ( async_rst_ni     ),
        .push_i        ( issue            ),
        .push_data_i   ( beat             ),
        .full_o        ( fifo_full        ),
        .almost_full_o (                  ),
        .pop_valid_o   ( res_valid_o      ),
        .pop_ready_i   ( res_ready_i      ),
        .pop_data_o    ( res_beat_o       )
    );

endmodule

`default_nettype wire

// ==== hw/vmux_result_fifo.sv ====
/* Result FIFO
   Circular buffer of generic payloads with full and almost-full status */

`timescale 1ns/1ps
`default_nettype none

`include "vmux_params.svh"

module vmux_result_fifo #(
    parameter type         PAYLOAD_T = logic,
    parameter int unsigned DEPTH     = `VMUX_FIFO_DEPTH
) (
    input  wire logic     clk_i,
    input  wire logic     async_rst_ni,
    input  wire logic     push_i,
    input  wire PAYLOAD_T push_data_i,
    output logic          full_o,
    output logic          almost_full_o,
    output logic          pop_valid_o,
    input  wire logic     pop_ready_i,
    output PAYLOAD_T      pop_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    PAYLOAD_T         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign pop_valid_o   = (count_q != '0);
    assign full_o        = (count_q == CNT_W'(DEPTH));
    assign almost_full_o = (count_q == CNT_W'(DEPTH - 1));
    assign pop_data_o    = mem_q[rd_ptr_q];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap explicitly so any depth works
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + CNT_W'(1);
            end else if (!do_push && do_pop) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/vmux_pkg.sv ====
/* Vector dispatcher types
   Unit and operation encodings, instruction control, operands and result beats */

`default_nettype none

`include "vmux_params.svh"

package vmux_pkg;

    localparam int unsigned ELEM_IDX_W = $clog2(`VMUX_ELEM_CNT);
    localparam int unsigned VEC_W      = `VMUX_ELEM_CNT * `VMUX_ELEM_W;

    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_e;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_e;

    typedef struct packed {
        unit_e                  unit;
        alu_op_e                op;
        logic [`VMUX_ID_W-1:0]  id;
        logic [ELEM_IDX_W-1:0]  vl_m1;
    } ctrl_t;

    // Element 0 sits in the low byte of each operand
    typedef struct packed {
        logic [VEC_W-1:0] op_a;
        logic [VEC_W-1:0] op_b;
    } operands_t;

    typedef struct packed {
        logic [`VMUX_ID_W-1:0]  id;
        unit_e                  unit;
        logic [ELEM_IDX_W-1:0]  elem;
        logic                   last;
        logic [`VMUX_RES_W-1:0] data;
    } res_beat_t;

    function automatic logic [`VMUX_ELEM_W-1:0] elem_sel(
        logic [VEC_W-1:0]      vec,
        logic [ELEM_IDX_W-1:0] idx
    );
        return vec[idx*`VMUX_ELEM_W +: `VMUX_ELEM_W];
    endfunction

endpackage

`default_nettype wire

// ==== hw/vmux_params.svh ====
/* Vector dispatcher parameters
   Element, id and result widths and the result FIFO depth */

`ifndef VMUX_PARAMS_SVH
`define VMUX_PARAMS_SVH

// Operand elements
`define VMUX_ELEM_W     8
`define VMUX_ELEM_CNT   4

// Instruction id and per-beat result
`define VMUX_ID_W       3
`define VMUX_RES_W      16

// Result FIFO entries per unit
`define VMUX_FIFO_DEPTH 4

`endif
